//--- alu.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module alu (
	alu_if.alu bus
);

logic [`DATA_N:0] sum;
bus_pkg::data_t res;
logic carry;

// Nine bit sum keeps the carry out
assign sum = {1'b0, bus.a} + {1'b0, bus.b} + {{`DATA_N{1'b0}}, bus.cin};

always_comb begin
	res = bus.b;
	carry = bus.cin;
	case (bus.func)
		isa_pkg::ADD: begin
			res = sum[`DATA_N - 1:0];
			carry = sum[`DATA_N];
		end
		isa_pkg::AND: begin
			res = bus.a & bus.b;
		end
		isa_pkg::EOR: begin
			res = bus.a ^ bus.b;
		end
		isa_pkg::INC: begin
			// Wraps at the top and leaves carry alone
			res = bus.a + 1'b1;
		end
		default: begin
			res = bus.b;
		end
	endcase
end

assign bus.result = res;
assign bus.flags.n = res[`DATA_N - 1];
assign bus.flags.z = (res == '0);
assign bus.flags.c = carry;

endmodule

`default_nettype wire

//--- alu_if.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

interface alu_if;

	bus_pkg::data_t a;
	bus_pkg::data_t b;
	isa_pkg::alu_func_t func;
	logic cin;

	bus_pkg::data_t result;
	isa_pkg::status_t flags;

	modport seq (
		output a, b, func, cin
	);

	modport alu (
		input a, b, func, cin,
		output result, flags
	);

endinterface

`default_nettype wire

//--- bus_pkg.sv
`include "cpu_defs.svh"
`default_nettype none

package bus_pkg;

	typedef logic [`ADDR_N - 1:0] addr_t;
	typedef logic [`DATA_N - 1:0] data_t;

	// One store as seen on the bus
	typedef struct packed {
		addr_t addr;
		data_t data;
	} mem_write_t;

endpackage

`default_nettype wire

//--- cpu.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module cpu (
	input wire clk_i,
	input wire rst_n_i,
	output bus_pkg::addr_t paddr_o,
	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output bus_pkg::data_t pwdata_o,
	input bus_pkg::data_t prdata_i,
	input wire pready_i,
	output logic halt_o
);

bus_pkg::addr_t pc_val, pc_load_val;
bus_pkg::data_t acc, x;
isa_pkg::status_t p;
logic acc_we, x_we, p_we;
logic pc_inc, pc_load;

alu_if alu_bus ();

alu alu0 (.bus(alu_bus.alu));

// Accumulator, X and flags all load from the ALU
register acc0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .we_i(acc_we),
		.d_i(alu_bus.result), .q_o(acc));
register x0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .we_i(x_we),
		.d_i(alu_bus.result), .q_o(x));
register #(.payload_t(isa_pkg::status_t)) p0 (.clk_i(clk_i), .rst_n_i(rst_n_i),
		.we_i(p_we), .d_i(alu_bus.flags), .q_o(p));

pc pc0 (.clk_i(clk_i), .rst_n_i(rst_n_i), .inc_i(pc_inc), .load_i(pc_load),
		.load_val_i(pc_load_val), .pc_o(pc_val));

sequencer seq0 (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.paddr_o(paddr_o),
	.psel_o(psel_o),
	.penable_o(penable_o),
	.pwrite_o(pwrite_o),
	.pwdata_o(pwdata_o),
	.prdata_i(prdata_i),
	.pready_i(pready_i),
	.pc_i(pc_val),
	.acc_i(acc),
	.x_i(x),
	.p_i(p),
	.alu(alu_bus.seq),
	.acc_we_o(acc_we),
	.x_we_o(x_we),
	.p_we_o(p_we),
	.pc_inc_o(pc_inc),
	.pc_load_o(pc_load),
	.pc_load_val_o(pc_load_val),
	.halt_o(halt_o)
);

endmodule

`default_nettype wire

//--- cpu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_checker (
	input wire clk_i,
	input wire rst_n_i,
	input bus_pkg::addr_t paddr_i,
	input wire psel_i,
	input wire penable_i,
	input wire pwrite_i,
	input bus_pkg::data_t pwdata_i,
	input wire pready_i,
	input wire halt_i
);

// Access phase only right after a setup phase
setup_before_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	$rose(penable_i) |-> $past(psel_i) && !$past(penable_i))
	else $error("APB access phase without a preceding setup phase");

enable_needs_select: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	penable_i |-> psel_i)
	else $error("APB penable high while psel is low");

// Address and write controls hold until the transfer completes
stable_in_transfer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	psel_i && !(penable_i && pready_i) |=>
		psel_i && $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
	else $error("APB address or write controls changed inside a transfer");

idle_after_transfer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	penable_i && pready_i |=> !psel_i)
	else $error("APB psel still high in the cycle after completion");

halt_sticks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	halt_i |=> halt_i)
	else $error("halt_o fell without a reset");

no_transfer_after_halt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
	halt_i |-> !psel_i)
	else $error("APB transfer started after halt");

endmodule

`default_nettype wire

//--- cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`default_nettype none

// Datapath widths
`define DATA_N 8
`define ADDR_N 16

// First fetch address out of reset
`define RESET_PC 16'h0000

// Upper bound on any wait for a bus event or halt
`define TIMEOUT_CYCLES 2000

`default_nettype wire

`endif

//--- cpu_patterns.txt
# M addr count bytes : memory image, count in decimal, then that many hex bytes
# W addr data : expected stores in order; H addr : expected HLT fetch address
M 0000 2 A9 00
M 0002 3 F0 08 00
M 0005 3 02 02 02
M 0008 3 AD 00 02
M 000B 3 8D 00 03
M 000E 4 69 20 69 05
M 0012 3 8D 01 03
M 0015 4 29 0F 49 FF
M 0019 3 8D 02 03
M 001C 3 F0 30 00
M 001F 4 A9 FE 69 03
M 0023 4 A9 FF AA E8
M 0027 3 8E 03 03
M 002A 3 F0 40 00
M 002D 1 02
M 0030 1 02
M 0040 2 69 00
M 0042 3 8D 04 03
M 0045 3 4C 50 00
M 0048 1 02
M 0050 4 E8 8E 05 03
M 0054 1 02
M 0200 1 F0
# LDA abs, carry chain, AND/EOR, INX wrap, carry kept by INX
W 0300 F0
W 0301 16
W 0302 F9
W 0303 00
W 0304 00
W 0305 01
H 0054

//--- isa_pkg.sv
`include "cpu_defs.svh"
`default_nettype none

package isa_pkg;

	// 6502 encodings where HLT borrows an unused slot
	typedef enum logic [`DATA_N - 1:0] {
		LDA_IMM = 8'hA9,
		LDA_ABS = 8'hAD,
		STA_ABS = 8'h8D,
		STX_ABS = 8'h8E,
		ADC_IMM = 8'h69,
		AND_IMM = 8'h29,
		EOR_IMM = 8'h49,
		TAX     = 8'hAA,
		INX     = 8'hE8,
		JMP_ABS = 8'h4C,
		BEQ_ABS = 8'hF0,
		HLT     = 8'h02
	} opcode_t;

	typedef enum logic [2:0] {
		ADD,
		AND,
		EOR,
		PASS_B,
		INC
	} alu_func_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
	} status_t;

endpackage

`default_nettype wire

//--- pc.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module pc (
	input wire clk_i,
	input wire rst_n_i,
	input wire inc_i,
	input wire load_i,
	input bus_pkg::addr_t load_val_i,
	output bus_pkg::addr_t pc_o
);

bus_pkg::addr_t pc_q;

// Jump target wins over the step
always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		pc_q <= `RESET_PC;
	end else if (load_i) begin
		pc_q <= load_val_i;
	end else if (inc_i) begin
		pc_q <= pc_q + 1'b1;
	end
end

assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- register.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module register #(
	parameter type payload_t = bus_pkg::data_t
) (
	input wire clk_i,
	input wire rst_n_i,
	input wire we_i,
	input payload_t d_i,
	output payload_t q_o
);

payload_t q;

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		q <= '0;
	end else if (we_i) begin
		q <= d_i;
	end
end

assign q_o = q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_cpu -o Vtb_cpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit 1
fi

exit 0

//--- sequencer.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module sequencer (
	input wire clk_i,
	input wire rst_n_i,

	output bus_pkg::addr_t paddr_o,
	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output bus_pkg::data_t pwdata_o,
	input bus_pkg::data_t prdata_i,
	input wire pready_i,

	input bus_pkg::addr_t pc_i,
	input bus_pkg::data_t acc_i,
	input bus_pkg::data_t x_i,
	input isa_pkg::status_t p_i,

	alu_if.seq alu,

	output logic acc_we_o,
	output logic x_we_o,
	output logic p_we_o,

	output logic pc_inc_o,
	output logic pc_load_o,
	output bus_pkg::addr_t pc_load_val_o,

	output logic halt_o
);

typedef enum logic [2:0] {
	ST_FETCH_SETUP,
	ST_FETCH_ACCESS,
	ST_OPL,
	ST_OPH,
	ST_RD,
	ST_WR,
	ST_EXEC,
	ST_HALT
} state_t;

// Operand and data transfers start with one idle cycle
typedef enum logic [1:0] {
	PH_IDLE,
	PH_SETUP,
	PH_ACCESS
} phase_t;

state_t state_q, state_d;
phase_t phase_q, phase_d;

isa_pkg::opcode_t opcode_q;
isa_pkg::opcode_t fetched;
bus_pkg::data_t opl_q, oph_q, data_q;

logic xfer, done, exec;

// Where an instruction goes once its opcode arrives
function automatic state_t after_fetch(input isa_pkg::opcode_t op);
	state_t nxt;
	case (op)
		isa_pkg::HLT: nxt = ST_HALT;
		isa_pkg::TAX, isa_pkg::INX: nxt = ST_EXEC;
		isa_pkg::LDA_IMM, isa_pkg::LDA_ABS, isa_pkg::STA_ABS, isa_pkg::STX_ABS,
		isa_pkg::ADC_IMM, isa_pkg::AND_IMM, isa_pkg::EOR_IMM,
		isa_pkg::JMP_ABS, isa_pkg::BEQ_ABS: nxt = ST_OPL;
		default: nxt = ST_EXEC;
	endcase
	return nxt;
endfunction

function automatic state_t after_xfer(input state_t st, input isa_pkg::opcode_t op);
	state_t nxt;
	nxt = ST_EXEC;
	case (st)
		ST_OPL: begin
			if (op inside {isa_pkg::LDA_ABS, isa_pkg::STA_ABS, isa_pkg::STX_ABS,
					isa_pkg::JMP_ABS, isa_pkg::BEQ_ABS}) begin
				nxt = ST_OPH;
			end
		end
		ST_OPH: begin
			if (op == isa_pkg::LDA_ABS) begin
				nxt = ST_RD;
			end else if (op == isa_pkg::STA_ABS || op == isa_pkg::STX_ABS) begin
				nxt = ST_WR;
			end
		end
		default: nxt = ST_EXEC;
	endcase
	return nxt;
endfunction

assign fetched = isa_pkg::opcode_t'(prdata_i);
assign xfer = (state_q inside {ST_OPL, ST_OPH, ST_RD, ST_WR});
assign exec = (state_q == ST_EXEC);

// APB master phases
assign psel_o = (state_q == ST_FETCH_SETUP) || (state_q == ST_FETCH_ACCESS) ||
		(xfer && phase_q != PH_IDLE);
assign penable_o = (state_q == ST_FETCH_ACCESS) || (xfer && phase_q == PH_ACCESS);
assign pwrite_o = (state_q == ST_WR) && (phase_q != PH_IDLE);
assign done = penable_o && pready_i;

assign paddr_o = (state_q == ST_RD || state_q == ST_WR) ? {oph_q, opl_q} : pc_i;
assign pwdata_o = (opcode_q == isa_pkg::STX_ABS) ? x_i : acc_i;

always_comb begin
	state_d = state_q;
	phase_d = phase_q;
	case (state_q)
		ST_FETCH_SETUP: state_d = ST_FETCH_ACCESS;
		ST_FETCH_ACCESS: begin
			if (pready_i) begin
				state_d = after_fetch(fetched);
				phase_d = PH_IDLE;
			end
		end
		ST_OPL, ST_OPH, ST_RD, ST_WR: begin
			case (phase_q)
				PH_IDLE: phase_d = PH_SETUP;
				PH_SETUP: phase_d = PH_ACCESS;
				default: begin
					if (pready_i) begin
						state_d = after_xfer(state_q, opcode_q);
						phase_d = PH_IDLE;
					end
				end
			endcase
		end
		ST_EXEC: state_d = ST_FETCH_SETUP;
		default: state_d = ST_HALT;
	endcase
end

// Reset parks in execute with a do-nothing opcode so psel starts low
always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		state_q <= ST_EXEC;
		phase_q <= PH_IDLE;
		opcode_q <= isa_pkg::HLT;
	end else begin
		state_q <= state_d;
		phase_q <= phase_d;
		if (state_q == ST_FETCH_ACCESS && pready_i) begin
			opcode_q <= fetched;
		end
	end
end

// Operand and data latches
always_ff @(posedge clk_i) begin
	if (done && state_q == ST_OPL) begin
		opl_q <= prdata_i;
	end
	if (done && state_q == ST_OPH) begin
		oph_q <= prdata_i;
	end
	if (done && state_q == ST_RD) begin
		data_q <= prdata_i;
	end
end

assign pc_inc_o = done && (state_q inside {ST_FETCH_ACCESS, ST_OPL, ST_OPH});
assign pc_load_val_o = {oph_q, opl_q};
assign pc_load_o = exec && ((opcode_q == isa_pkg::JMP_ABS) ||
		(opcode_q == isa_pkg::BEQ_ABS && p_i.z));

// Execute step
always_comb begin
	alu.a = acc_i;
	alu.b = opl_q;
	alu.func = isa_pkg::PASS_B;
	alu.cin = p_i.c;
	acc_we_o = 1'b0;
	x_we_o = 1'b0;
	p_we_o = 1'b0;
	case (opcode_q)
		isa_pkg::LDA_IMM: begin
			acc_we_o = exec;
			p_we_o = exec;
		end
		isa_pkg::LDA_ABS: begin
			alu.b = data_q;
			acc_we_o = exec;
			p_we_o = exec;
		end
		isa_pkg::ADC_IMM, isa_pkg::AND_IMM, isa_pkg::EOR_IMM: begin
			if (opcode_q == isa_pkg::ADC_IMM) begin
				alu.func = isa_pkg::ADD;
			end else if (opcode_q == isa_pkg::AND_IMM) begin
				alu.func = isa_pkg::AND;
			end else begin
				alu.func = isa_pkg::EOR;
			end
			acc_we_o = exec;
			p_we_o = exec;
		end
		isa_pkg::TAX: begin
			alu.b = acc_i;
			x_we_o = exec;
			p_we_o = exec;
		end
		isa_pkg::INX: begin
			alu.a = x_i;
			alu.func = isa_pkg::INC;
			x_we_o = exec;
			p_we_o = exec;
		end
		default: begin
			alu.func = isa_pkg::PASS_B;
		end
	endcase
end

assign halt_o = (state_q == ST_HALT);

endmodule

`default_nettype wire

//--- tb_cpu.sv
`timescale 1ns/100ps
`include "cpu_defs.svh"
`default_nettype none

module tb_cpu;

localparam int unsigned RNG_SEED = 20908;
localparam string PATTERN_FILE = "cpu_patterns.txt";

logic clk_i;
logic rst_n_i;
bus_pkg::data_t prdata_i;
logic pready_i;
bus_pkg::addr_t paddr_o;
logic psel_o;
logic penable_o;
logic pwrite_o;
bus_pkg::data_t pwdata_o;
logic halt_o;

// Slave memory and expected results
bus_pkg::data_t mem [0:65535];
bus_pkg::mem_write_t exp_writes[$];
bus_pkg::addr_t exp_halt;
bus_pkg::addr_t last_read;
logic have_halt;
logic first_xfer;
int store_cnt;
int run_cycles;

cpu i_dut (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.paddr_o(paddr_o),
	.psel_o(psel_o),
	.penable_o(penable_o),
	.pwrite_o(pwrite_o),
	.pwdata_o(pwdata_o),
	.prdata_i(prdata_i),
	.pready_i(pready_i),
	.halt_o(halt_o)
);

bind cpu cpu_checker i_checker (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.paddr_i(paddr_o),
	.psel_i(psel_o),
	.penable_i(penable_o),
	.pwrite_i(pwrite_o),
	.pwdata_i(pwdata_o),
	.pready_i(pready_i),
	.halt_i(halt_o)
);

always #10 clk_i = ~clk_i;

task automatic fail_run(input string msg);
	$display("%s", msg);
	$display("Testbench failed");
	$fatal(1);
endtask

task automatic check_level(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		fail_run($sformatf("** Error at time %0t: %s is %b, expected %b",
				$time, what, got, exp));
	end
endtask

task automatic check_addr(input string what, input bus_pkg::addr_t got,
		input bus_pkg::addr_t exp);
	if (got !== exp) begin
		fail_run($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	end
endtask

task automatic check_write(input int idx, input bus_pkg::mem_write_t got);
	if (idx >= exp_writes.size()) begin
		fail_run($sformatf("** Error at time %0t: store %0d of %h to %h, only %0d expected",
				$time, idx, got.data, got.addr, exp_writes.size()));
	end else if (got !== exp_writes[idx]) begin
		fail_run($sformatf("** Error at time %0t: store %0d wrote %h to %h, expected %h to %h",
				$time, idx, got.data, got.addr, exp_writes[idx].data,
				exp_writes[idx].addr));
	end
endtask

task automatic check_halt(input bus_pkg::addr_t got, input bus_pkg::addr_t exp);
	if (got !== exp) begin
		fail_run($sformatf("** Error at time %0t: HLT fetched from %h, expected %h",
				$time, got, exp));
	end
endtask

// Idle cycles between the HLT fetch completing and halt_o rising
task automatic check_halt_delay(input int got);
	if (got != 0) begin
		fail_run($sformatf("** Error at time %0t: halt_o rose %0d cycles late",
				$time, got));
	end
endtask

task automatic check_count(input int got, input int exp);
	if (got != exp) begin
		fail_run($sformatf("** Error at time %0t: %0d stores seen, expected %0d",
				$time, got, exp));
	end
endtask

// Inputs change 2 ns after the rising edge
task automatic next_cycle;
	@(posedge clk_i);
	#2;
	run_cycles++;
endtask

task automatic read_patterns;
	int fd;
	int code;
	int count;
	int i;
	logic [7:0] tag;
	logic [8*120-1:0] rest;
	logic [15:0] a;
	logic [7:0] d;
	bus_pkg::mem_write_t w;
	fd = $fopen(PATTERN_FILE, "r");
	if (fd == 0) begin
		fail_run("Could not open the pattern file cpu_patterns.txt");
	end
	while (!$feof(fd)) begin
		code = $fscanf(fd, "%s", tag);
		if (code == 1) begin
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "M") begin
				code = $fscanf(fd, "%h %d", a, count);
				for (i = 0; i < count; i++) begin
					code = $fscanf(fd, "%h", d);
					mem[a] = d;
					a = a + 16'd1;
				end
			end else if (tag == "W") begin
				code = $fscanf(fd, "%h %h", a, d);
				w.addr = a;
				w.data = d;
				exp_writes.push_back(w);
			end else if (tag == "H") begin
				code = $fscanf(fd, "%h", a);
				exp_halt = a;
				have_halt = 1'b1;
			end else begin
				fail_run("The pattern file holds a line of unknown kind");
			end
		end
	end
	$fclose(fd);
	if (!have_halt) begin
		fail_run("The pattern file gives no expected halt address");
	end
endtask

// Called in the setup cycle, returns after the completing edge
task automatic serve_transfer;
	bus_pkg::addr_t addr;
	bus_pkg::data_t wdata;
	logic wr;
	int waits;
	bus_pkg::mem_write_t got;
	addr = paddr_o;
	wr = pwrite_o;
	wdata = pwdata_o;
	check_level("penable_o in setup phase", penable_o, 1'b0);
	if (first_xfer) begin
		check_addr("first transfer address", addr, `RESET_PC);
		check_level("pwrite_o of first transfer", wr, 1'b0);
		first_xfer = 1'b0;
	end
	waits = int'($urandom % 4);
	next_cycle();
	prdata_i = wr ? 8'h00 : mem[addr];
	check_level("penable_o in access phase", penable_o, 1'b1);
	while (waits > 0) begin
		next_cycle();
		check_level("penable_o in access phase", penable_o, 1'b1);
		waits--;
	end
	pready_i = 1'b1;
	next_cycle();
	pready_i = 1'b0;
	if (wr) begin
		got.addr = addr;
		got.data = wdata;
		check_write(store_cnt, got);
		mem[addr] = wdata;
		store_cnt++;
	end else begin
		last_read = addr;
	end
endtask

initial begin
	int idle;
	int k;
	clk_i = 1'b0;
	rst_n_i = 1'b0;
	prdata_i = 8'h00;
	pready_i = 1'b0;
	have_halt = 1'b0;
	first_xfer = 1'b1;
	store_cnt = 0;
	run_cycles = 0;
	last_read = 16'h0000;
	exp_halt = 16'h0000;
	void'($urandom(RNG_SEED));
	// Background image that depends on every address bit
	for (k = 0; k < 65536; k++) begin
		mem[k[15:0]] = k[7:0] ^ k[15:8] ^ 8'h3C;
	end
	read_patterns();

	repeat (3) @(posedge clk_i);
	#2;
	rst_n_i = 1'b1;
	check_level("psel_o after reset", psel_o, 1'b0);
	check_level("penable_o after reset", penable_o, 1'b0);
	check_level("pwrite_o after reset", pwrite_o, 1'b0);
	check_level("halt_o after reset", halt_o, 1'b0);

	idle = 0;
	while (!halt_o) begin
		if (run_cycles > `TIMEOUT_CYCLES) begin
			fail_run("Timed out: the CPU never reached its HLT instruction");
		end
		if (psel_o) begin
			serve_transfer();
			idle = 0;
		end else begin
			next_cycle();
			idle++;
			if (idle > `TIMEOUT_CYCLES) begin
				fail_run("Timed out waiting for the next bus transfer");
			end
		end
	end

	check_halt(last_read, exp_halt);
	check_halt_delay(idle);
	check_count(store_cnt, exp_writes.size());
	// Halted core stays quiet
	for (k = 0; k < 20; k++) begin
		next_cycle();
		check_level("psel_o after halt", psel_o, 1'b0);
		check_level("halt_o after halt", halt_o, 1'b1);
	end
	$display("Testbench passed");
	$finish;
end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
isa_pkg.sv
bus_pkg.sv
alu_if.sv
register.sv
alu.sv
pc.sv
sequencer.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv
